// ==== list.f ====
+incdir+.
uart_pkg.sv
byte_link_if.sv
uart_tx.sv
uart_rx.sv
uart_link_ctrl.sv
uart_component.sv
tb_uart_component.sv

// ==== Bender.yml ====
package:
  name: uart_component

export_include_dirs:
  - .

sources:
  - files:
      - uart_pkg.sv
      - byte_link_if.sv
      - uart_tx.sv
      - uart_rx.sv
      - uart_link_ctrl.sv
      - uart_component.sv
  - target: test
    files:
      - tb_uart_component.sv

// ==== tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
        $display("mismatch %s: expected %h, actual %h", name, exp, act);
        mismatch_count++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("mismatch %s: expected %b, actual %b", name, exp, act);
        mismatch_count++;
    end
endtask

// ------------------------------
// System bus access
// ------------------------------
// Write lands on the second rising edge
task automatic bus_write(input addr_t addr, input byte_t data);
    @(posedge clock);
    cs_i   <= 1'b0;
    wr_i   <= 1'b0;
    addr_i <= addr;
    data_i <= data;
    @(posedge clock);
    cs_i   <= 1'b1;
    wr_i   <= 1'b1;
endtask

// Read data is combinational, sampled on the falling edge
task automatic poll_register(input string name, input addr_t addr, input byte_t exp);
    int unsigned waited;
    byte_t       value;
    waited = 0;
    @(posedge clock);
    addr_i <= addr;
    @(negedge clock);
    value = data_o;
    while (value !== exp && waited < WAIT_LIMIT) begin
        @(negedge clock);
        value = data_o;
        waited++;
    end
    check_byte(name, exp, value);
endtask

// Single bit of a register
task automatic poll_flag(input string name, input addr_t addr, input int idx, input logic exp);
    int unsigned waited;
    waited = 0;
    @(posedge clock);
    addr_i <= addr;
    @(negedge clock);
    while (data_o[idx] !== exp && waited < WAIT_LIMIT) begin
        @(negedge clock);
        waited++;
    end
    check_flag(name, exp, data_o[idx]);
endtask

// ------------------------------
// Serial line
// ------------------------------
// 8N1 frame into rx_i, LSB first
task automatic send_serial(input byte_t value);
    logic [FRAME_BITS-1:0] frame;
    int                    i;
    frame = {1'b1, value, 1'b0};
    for (i = 0; i < FRAME_BITS; i++) begin
        @(posedge clock);
        rx_i <= frame[i];
        repeat (CPB - 1) @(posedge clock);
    end
endtask

// Start bit found, then each bit sampled at its middle
task automatic expect_serial(input string name, input byte_t exp);
    int unsigned waited;
    byte_t       value;
    int          i;
    waited = 0;
    value  = '0;
    @(negedge clock);
    while (tx_o !== 1'b0 && waited < WAIT_LIMIT) begin
        @(negedge clock);
        waited++;
    end
    if (tx_o !== 1'b0) begin
        $display("no start bit appeared on tx_o during %s", name);
        fail_count++;
    end else begin
        repeat (CPB / 2) @(negedge clock);
        check_flag({name, " start bit"}, 1'b0, tx_o);
        for (i = 0; i < DATA_W; i++) begin
            repeat (CPB) @(negedge clock);
            value[i] = tx_o;
        end
        repeat (CPB) @(negedge clock);
        check_flag({name, " stop bit"}, 1'b1, tx_o);
        check_byte(name, exp, value);
    end
endtask

// Pulse is high for exactly two cycles
task automatic wait_irq(input string name);
    int unsigned waited;
    waited = 0;
    @(negedge clock);
    while (irq_o !== 1'b1 && waited < WAIT_LIMIT) begin
        @(negedge clock);
        waited++;
    end
    check_flag(name, 1'b1, irq_o);
    @(negedge clock);
    check_flag({name, " second cycle"}, 1'b1, irq_o);
    @(negedge clock);
    check_flag({name, " end"}, 1'b0, irq_o);
endtask

`endif

// ==== tb_uart_component.sv ====
`timescale 1ns/100ps
`include "uart_params.svh"

module tb_uart_component;
    import uart_pkg::*;

    localparam int CPB        = `UART_CLKS_PER_BIT;
    localparam int DATA_W     = `UART_DATA_WIDTH;
    localparam int FRAME_BITS = DATA_W + 2;
    // Longest single wait, a bit over one frame
    localparam int WAIT_LIMIT = 12 * CPB;

    typedef enum {OP_WR, OP_RD, OP_FLAG, OP_SER_IN, OP_SER_OUT, OP_IRQ} op_e;

    logic  clock;
    logic  reset;
    logic  cs_i;
    logic  wr_i;
    addr_t addr_i;
    byte_t data_i;
    byte_t data_o;
    logic  rx_i;
    logic  tx_o;
    logic  irq_o;

    int unsigned mismatch_count = 0;
    int unsigned fail_count     = 0;
    int unsigned cycle_count    = 0;
    int unsigned cycle_limit    = 0;

    // Stimulus table, one column per queue
    string step_name[$];
    op_e   step_op[$];
    addr_t step_addr[$];
    byte_t step_data[$];
    int    step_bit[$];

    `include "tb_uart_tasks.svh"

    uart_component uut (
        .clock  (clock),
        .reset  (reset),
        .cs_i   (cs_i),
        .wr_i   (wr_i),
        .addr_i (addr_i),
        .data_i (data_i),
        .data_o (data_o),
        .rx_i   (rx_i),
        .tx_o   (tx_o),
        .irq_o  (irq_o)
    );

    // 40 ns period
    always #20 clock = ~clock;

    function automatic void add_step(string name, op_e op, addr_t addr, byte_t data, int idx);
        step_name.push_back(name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_bit.push_back(idx);
    endfunction

    function automatic byte_t bit_mask(input int idx);
        return byte_t'(1) << idx;
    endfunction

    // Signal code on top, random low nibble
    function automatic byte_t coded_byte(input logic [3:0] code);
        return byte_t'({code, 4'($urandom())});
    endfunction

    // ------------------------------
    // Timeout watchdog
    // ------------------------------
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
            $display("sim failed");
            $finish;
        end
    end

    initial begin : main
        byte_t key_irq;
        byte_t key_poll;
        byte_t sys_data;
        byte_t sys_eos;
        byte_t plain;
        byte_t ack;
        byte_t stream_ctl1;
        int    idx;

        void'($urandom(82));
        clock  = 1'b0;
        reset  = 1'b0;
        cs_i   = 1'b1;
        wr_i   = 1'b1;
        addr_i = '0;
        data_i = '0;
        rx_i   = 1'b1;

        key_irq  = byte_t'($urandom());
        key_poll = byte_t'($urandom());
        // Top bit set keeps these out of the signal codes
        sys_data = byte_t'({1'b1, 7'($urandom())});
        plain    = byte_t'({1'b1, 7'($urandom())});
        sys_eos  = coded_byte(SIG_EOS);
        ack      = coded_byte(SIG_ACK);
        stream_ctl1 = bit_mask(CLI_GRNT) | bit_mask(KEY_RDY) | bit_mask(STR_BOS) |
                      bit_mask(STR_DAT) | bit_mask(STR_EOS) | bit_mask(STR_BYT);

        // Registers clear after reset, TX buffer reads zero
        add_step("reset key", OP_RD, `UART_ADDR_KEY, 8'h00, 0);
        add_step("reset ctl1", OP_RD, `UART_ADDR_CTL1, 8'h00, 0);
        add_step("reset ctl2", OP_RD, `UART_ADDR_CTL2, 8'h00, 0);
        add_step("reset rxbuf", OP_RD, `UART_ADDR_RXBUF, 8'h00, 0);
        add_step("reset txbuf", OP_RD, `UART_ADDR_TXBUF, 8'h00, 0);
        // Key-code with interrupt
        add_step("irq enable", OP_WR, `UART_ADDR_CTL1, bit_mask(IRQ_EN), 0);
        add_step("irq key", OP_SER_IN, '0, coded_byte(SIG_KEY), 0);
        add_step("irq code", OP_SER_IN, '0, key_irq, 0);
        add_step("irq pulse", OP_IRQ, '0, 8'h00, 0);
        add_step("irq keycode", OP_RD, `UART_ADDR_KEY, key_irq, 0);
        // Key-code with polling
        add_step("poll mode", OP_WR, `UART_ADDR_CTL1, 8'h00, 0);
        add_step("poll key", OP_SER_IN, '0, coded_byte(SIG_KEY), 0);
        add_step("poll code", OP_SER_IN, '0, key_poll, 0);
        add_step("poll key_rdy", OP_FLAG, `UART_ADDR_CTL1, 8'h01, KEY_RDY);
        add_step("poll keycode", OP_RD, `UART_ADDR_KEY, key_poll, 0);
        // System transmit
        add_step("sys request", OP_WR, `UART_ADDR_CTL2, bit_mask(SYS_REQ), 0);
        add_step("sys grant", OP_FLAG, `UART_ADDR_CTL2, 8'h01, SYS_GRNT);
        add_step("sys write", OP_WR, `UART_ADDR_TXBUF, sys_data, 0);
        add_step("sys serial", OP_SER_OUT, '0, sys_data, 0);
        add_step("sys trx_cmp", OP_FLAG, `UART_ADDR_CTL2, 8'h01, TRX_CMP);
        add_step("sys dev_trx", OP_FLAG, `UART_ADDR_CTL2, 8'h00, DEV_TRX);
        // EOS hands control back
        add_step("eos write", OP_WR, `UART_ADDR_TXBUF, sys_eos, 0);
        add_step("eos serial", OP_SER_OUT, '0, sys_eos, 0);
        add_step("eos release", OP_FLAG, `UART_ADDR_CTL2, 8'h00, SYS_GRNT);
        // Client grant
        add_step("cli crc", OP_SER_IN, '0, coded_byte(SIG_CRC), 0);
        add_step("cli rgc", OP_SER_OUT, '0, byte_t'({SIG_RGC, 4'h0}), 0);
        add_step("cli grant", OP_FLAG, `UART_ADDR_CTL1, 8'h01, CLI_GRNT);
        // Client stream
        add_step("stream bos", OP_SER_IN, '0, coded_byte(SIG_BOS), 0);
        add_step("stream dat", OP_SER_IN, '0, coded_byte(SIG_DAT), 0);
        add_step("stream eos", OP_SER_IN, '0, coded_byte(SIG_EOS), 0);
        add_step("stream byte", OP_SER_IN, '0, plain, 0);
        add_step("stream flags", OP_RD, `UART_ADDR_CTL1, stream_ctl1, 0);
        add_step("stream rxbuf", OP_RD, `UART_ADDR_RXBUF, plain, 0);
        add_step("stream ack write", OP_WR, `UART_ADDR_TXBUF, ack, 0);
        add_step("stream ack serial", OP_SER_OUT, '0, ack, 0);
        add_step("stream txbuf", OP_RD, `UART_ADDR_TXBUF, 8'h00, 0);

        cycle_limit = step_op.size() * (12 * CPB + 40);

        repeat (3) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_flag("reset tx_o idle", 1'b1, tx_o);
        check_flag("reset irq_o low", 1'b0, irq_o);

        // ------------------------------
        // Apply the table
        // ------------------------------
        for (idx = 0; idx < step_op.size(); idx++) begin
            case (step_op[idx])
                OP_WR:      bus_write(step_addr[idx], step_data[idx]);
                OP_RD:      poll_register(step_name[idx], step_addr[idx], step_data[idx]);
                OP_FLAG:    poll_flag(step_name[idx], step_addr[idx], step_bit[idx],
                                      step_data[idx][0]);
                OP_SER_IN:  send_serial(step_data[idx]);
                OP_SER_OUT: expect_serial(step_name[idx], step_data[idx]);
                default:    wait_irq(step_name[idx]);
            endcase
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== uart_component.sv ====
`timescale 1ns/100ps

module uart_component (
    input  logic            clock,
    input  logic            reset,
    // System bus, strobes active low
    input  logic            cs_i,
    input  logic            wr_i,
    input  uart_pkg::addr_t addr_i,
    input  uart_pkg::byte_t data_i,
    output uart_pkg::byte_t data_o,
    // Client serial line
    input  logic            rx_i,
    output logic            tx_o,
    output logic            irq_o
);

    // Byte handshakes between controller and engines
    byte_link_if link ();

    // ------------------------------
    // Register file and protocol
    // ------------------------------
    uart_link_ctrl u_ctrl (
        .clock  (clock),
        .reset  (reset),
        .cs_i   (cs_i),
        .wr_i   (wr_i),
        .addr_i (addr_i),
        .data_i (data_i),
        .data_o (data_o),
        .irq_o  (irq_o),
        .link   (link.ctrl)
    );

    // ------------------------------
    // Serial engines
    // ------------------------------
    uart_tx u_tx (
        .clock (clock),
        .reset (reset),
        .link  (link.tx),
        .tx_o  (tx_o)
    );

    uart_rx u_rx (
        .clock (clock),
        .reset (reset),
        .rx_i  (rx_i),
        .link  (link.rx)
    );

endmodule

// ==== uart_link_ctrl.sv ====
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_link_ctrl (
    input  logic             clock,
    input  logic             reset,
    input  logic             cs_i,
    input  logic             wr_i,
    input  uart_pkg::addr_t  addr_i,
    input  uart_pkg::byte_t  data_i,
    output uart_pkg::byte_t  data_o,
    output logic             irq_o,
    byte_link_if.ctrl        link
);
    import uart_pkg::*;

    // ------------------------------
    // Register file
    // ------------------------------
    byte_t       key_q;
    byte_t       ctl1_q;
    byte_t       ctl2_q;
    byte_t       rx_buf_q;
    byte_t       tx_buf_q;

    link_state_e state_q;
    logic        rx_ack_q;
    logic        irq_q;

    // Bus decode
    logic        wr_en;
    logic        ctl1_wr;
    logic        ctl2_wr;
    logic        txb_wr;

    logic        rx_take;
    logic        neither_ctl;
    logic [3:0]  rx_code;
    logic [3:0]  tx_code;

    // Both strobes active low
    assign wr_en   = !cs_i && !wr_i;
    assign ctl1_wr = wr_en && (addr_i == `UART_ADDR_CTL1);
    assign ctl2_wr = wr_en && (addr_i == `UART_ADDR_CTL2);

    // System needs control, except for an ACK
    assign txb_wr = wr_en && (addr_i == `UART_ADDR_TXBUF) &&
                    (ctl2_q[SYS_GRNT] || (data_i[7:4] == SIG_ACK));

    assign neither_ctl = !ctl1_q[CLI_GRNT] && !ctl2_q[SYS_GRNT];
    assign rx_code     = rx_buf_q[7:4];
    assign tx_code     = tx_buf_q[7:4];

    // Key-code and buffers read back, TX buffer reads zero
    always_comb begin
        case (addr_i)
            `UART_ADDR_KEY:   data_o = key_q;
            `UART_ADDR_CTL1:  data_o = ctl1_q;
            `UART_ADDR_CTL2:  data_o = ctl2_q;
            `UART_ADDR_RXBUF: data_o = rx_buf_q;
            default:          data_o = '0;
        endcase
    end

    // States that accept a received byte
    // Ack cycle is skipped so the same byte is not taken twice
    always_comb begin
        case (state_q)
            DEV_IDLE, KEY_WAIT, CLI_IDLE, SYS_IDLE: rx_take = link.rx_valid && !rx_ack_q;
            default:                                rx_take = 1'b0;
        endcase
    end

    // ------------------------------
    // Protocol FSM
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            state_q  <= DEV_IDLE;
            key_q    <= '0;
            ctl1_q   <= '0;
            ctl2_q   <= '0;
            rx_buf_q <= '0;
            tx_buf_q <= '0;
            rx_ack_q <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            // Ack goes out one cycle after capture
            rx_ack_q <= rx_take;

            case (state_q)
                // Client byte first, then a System request
                DEV_IDLE: begin
                    if (rx_take) begin
                        rx_buf_q <= link.rx_byte;
                        state_q  <= DEV_CHECK;
                    end else if (neither_ctl && ctl2_q[SYS_REQ]) begin
                        ctl2_q[SYS_GRNT] <= 1'b1;
                        ctl2_q[SYS_REQ]  <= 1'b0;
                        state_q          <= SYS_IDLE;
                    end
                end

                DEV_CHECK: begin
                    if (rx_code == SIG_KEY) begin
                        state_q <= KEY_WAIT;
                    end else if (rx_code == SIG_CRC && neither_ctl) begin
                        ctl1_q[CLI_GRNT] <= 1'b1;
                        state_q          <= RGC_START;
                    end else begin
                        state_q <= DEV_IDLE;
                    end
                end

                // Next byte is the key-code itself
                KEY_WAIT: begin
                    if (rx_take) begin
                        key_q <= link.rx_byte;
                        if (ctl1_q[IRQ_EN]) begin
                            irq_q <= 1'b1;
                        end else begin
                            ctl1_q[KEY_RDY] <= 1'b1;
                        end
                        state_q <= KEY_ACK;
                    end
                end

                // irq high through these two cycles
                KEY_ACK: begin
                    state_q <= KEY_EXIT;
                end

                KEY_EXIT: begin
                    irq_q   <= 1'b0;
                    state_q <= DEV_IDLE;
                end

                // Grant reply to the Client
                RGC_START: begin
                    state_q <= RGC_SEND;
                end

                RGC_SEND: begin
                    if (link.tx_done) begin
                        state_q <= CLI_IDLE;
                    end
                end

                CLI_IDLE: begin
                    if (rx_take) begin
                        rx_buf_q <= link.rx_byte;
                        state_q  <= CLI_CHECK;
                    end else if (ctl2_q[DEV_TRX]) begin
                        state_q <= TRX_START;
                    end
                end

                // One stream flag per received byte
                CLI_CHECK: begin
                    case (rx_code)
                        SIG_BOS: ctl1_q[STR_BOS] <= 1'b1;
                        SIG_DAT: ctl1_q[STR_DAT] <= 1'b1;
                        SIG_EOS: ctl1_q[STR_EOS] <= 1'b1;
                        default: ctl1_q[STR_BYT] <= 1'b1;
                    endcase
                    state_q <= CLI_IDLE;
                end

                // Client bytes are taken and ignored here
                SYS_IDLE: begin
                    if (rx_take) begin
                        rx_buf_q <= link.rx_byte;
                    end else if (!ctl2_q[SYS_GRNT]) begin
                        state_q <= DEV_IDLE;
                    end else if (ctl2_q[DEV_TRX]) begin
                        state_q <= TRX_START;
                    end
                end

                TRX_START: begin
                    ctl2_q[DEV_TRX] <= 1'b0;
                    ctl2_q[TRX_CMP] <= 1'b0;
                    state_q         <= TRX_SEND;
                end

                TRX_SEND: begin
                    if (link.tx_done) begin
                        ctl2_q[TRX_CMP] <= 1'b1;
                        if (ctl1_q[CLI_GRNT]) begin
                            state_q <= CLI_IDLE;
                        end else if (tx_code == SIG_EOS) begin
                            // End of stream hands control back
                            ctl2_q[SYS_GRNT] <= 1'b0;
                            state_q          <= DEV_IDLE;
                        end else if (ctl2_q[SYS_GRNT]) begin
                            state_q <= SYS_IDLE;
                        end else begin
                            state_q <= DEV_IDLE;
                        end
                    end
                end

                default: begin
                    state_q <= DEV_IDLE;
                end
            endcase

            // Bus writes last, they override FSM updates
            if (txb_wr) begin
                tx_buf_q        <= data_i;
                ctl2_q[DEV_TRX] <= 1'b1;
            end
            if (ctl1_wr) begin
                ctl1_q <= data_i;
            end
            if (ctl2_wr) begin
                ctl2_q <= data_i;
            end
        end
    end

    // ------------------------------
    // Link outputs
    // ------------------------------
    assign link.tx_start = (state_q == RGC_START) || (state_q == TRX_START);
    assign link.tx_byte  = (state_q == RGC_START) ? byte_t'({SIG_RGC, 4'h0}) : tx_buf_q;
    assign link.rx_ack   = rx_ack_q;
    assign irq_o         = irq_q;

    // Only one party ever holds the link
    a_one_grant: assert property (@(posedge clock) disable iff (!reset)
        !(ctl1_q[CLI_GRNT] && ctl2_q[SYS_GRNT]));

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_rx (
    input  logic    clock,
    input  logic    reset,
    input  logic    rx_i,
    byte_link_if.rx link
);
    import uart_pkg::*;

    localparam int CPB    = `UART_CLKS_PER_BIT;
    localparam int HALF   = (CPB > 1) ? CPB / 2 : 1;
    localparam int BAUD_W = (CPB > 1) ? $clog2(CPB) : 1;
    localparam int BIT_W  = $clog2(`UART_DATA_WIDTH + 2);

    // Line synchronizer plus edge history
    logic              sync1_q;
    logic              sync2_q;
    logic              line_prev_q;

    logic              busy_q;
    logic [BAUD_W-1:0] baud_q;
    logic [BIT_W-1:0]  bit_q;
    byte_t             shift_q;
    byte_t             data_q;
    logic              valid_q;

    logic              start_edge;
    logic              sample;
    logic              stop_bit;

    // ------------------------------
    // Synchronizer
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            sync1_q     <= 1'b1;
            sync2_q     <= 1'b1;
            line_prev_q <= 1'b1;
        end else begin
            sync1_q     <= rx_i;
            sync2_q     <= sync1_q;
            line_prev_q <= sync2_q;
        end
    end

    // Falling edge while idle
    assign start_edge = !busy_q && line_prev_q && !sync2_q;

    // Start bit sampled after half a bit, others a full bit later
    assign sample = busy_q && ((bit_q == '0) ? (baud_q == BAUD_W'(HALF - 1))
                                              : (baud_q == BAUD_W'(CPB - 1)));
    assign stop_bit = (bit_q == BIT_W'(`UART_DATA_WIDTH + 1));

    // ------------------------------
    // Frame control
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            busy_q  <= 1'b0;
            baud_q  <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
            data_q  <= '0;
        end else begin
            if (start_edge) begin
                busy_q <= 1'b1;
                baud_q <= '0;
                bit_q  <= '0;
            end else if (sample) begin
                baud_q <= '0;
                bit_q  <= bit_q + 1'b1;
                // Glitch, not a real start bit
                if ((bit_q == '0) && sync2_q) begin
                    busy_q <= 1'b0;
                end else if (stop_bit) begin
                    busy_q <= 1'b0;
                end
            end else if (busy_q) begin
                baud_q <= baud_q + 1'b1;
            end

            // Good stop bit and buffer free, else frame is dropped
            if (sample && stop_bit && sync2_q && !valid_q) begin
                valid_q <= 1'b1;
                data_q  <= shift_q;
            end else if (link.rx_ack) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Data bits, LSB first
    always_ff @(posedge clock) begin
        if (sample && (bit_q != '0) && !stop_bit) begin
            shift_q <= {sync2_q, shift_q[`UART_DATA_WIDTH-1:1]};
        end
    end

    assign link.rx_valid = valid_q;
    assign link.rx_byte  = data_q;

    // Ack only for a byte that is actually held
    a_ack_valid: assert property (@(posedge clock) disable iff (!reset)
        link.rx_ack |-> valid_q);

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps
`include "uart_params.svh"

module uart_tx (
    input  logic    clock,
    input  logic    reset,
    byte_link_if.tx link,
    output logic    tx_o
);

    localparam int CPB        = `UART_CLKS_PER_BIT;
    localparam int BAUD_W     = (CPB > 1) ? $clog2(CPB) : 1;
    localparam int FRAME_BITS = `UART_DATA_WIDTH + 2;
    localparam int BIT_W      = $clog2(FRAME_BITS);

    logic                  busy_q;
    logic [BAUD_W-1:0]     baud_q;
    logic [BIT_W-1:0]      bit_q;
    // Stop, data LSB first, start
    logic [FRAME_BITS-1:0] frame_q;
    logic                  baud_end;
    logic                  last_bit;

    assign baud_end = (baud_q == BAUD_W'(CPB - 1));
    assign last_bit = (bit_q == BIT_W'(FRAME_BITS - 1));

    // ------------------------------
    // Bit and baud counters
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            busy_q <= 1'b0;
            baud_q <= '0;
            bit_q  <= '0;
        end else if (!busy_q) begin
            if (link.tx_start) begin
                busy_q <= 1'b1;
                baud_q <= '0;
                bit_q  <= '0;
            end
        end else if (baud_end) begin
            baud_q <= '0;
            bit_q  <= bit_q + 1'b1;
            // Frame ends after the stop bit
            if (last_bit) begin
                busy_q <= 1'b0;
            end
        end else begin
            baud_q <= baud_q + 1'b1;
        end
    end

    // Shift register, refilled with idle ones
    always_ff @(posedge clock) begin
        if (!busy_q && link.tx_start) begin
            frame_q <= {1'b1, link.tx_byte, 1'b0};
        end else if (busy_q && baud_end) begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        end
    end

    // Line idles high
    assign tx_o = busy_q ? frame_q[0] : 1'b1;

    assign link.tx_done = busy_q & baud_end & last_bit;

    // Controller only starts an idle transmitter
    a_start_idle: assert property (@(posedge clock) disable iff (!reset)
        link.tx_start |-> !busy_q);

endmodule

// ==== byte_link_if.sv ====
`timescale 1ns/100ps

interface byte_link_if;
    import uart_pkg::*;

    // ------------------------------
    // Transmit side
    // ------------------------------
    // Start pulse, byte must be stable with it
    logic  tx_start;
    byte_t tx_byte;
    // Pulses in the last stop-bit cycle
    logic  tx_done;

    // ------------------------------
    // Receive side
    // ------------------------------
    // Level, held until the cycle after rx_ack
    logic  rx_valid;
    byte_t rx_byte;
    logic  rx_ack;

    // Controller view
    modport ctrl (output tx_start, tx_byte, rx_ack, input tx_done, rx_valid, rx_byte);

    // Serial transmitter view
    modport tx (input tx_start, tx_byte, output tx_done);

    // Serial receiver view
    modport rx (output rx_valid, rx_byte, input rx_ack);

endinterface

// ==== uart_pkg.sv ====
`include "uart_params.svh"

package uart_pkg;

    // ------------------------------
    // Basic data types
    // ------------------------------
    typedef logic [`UART_DATA_WIDTH-1:0] byte_t;
    typedef logic [`UART_ADDR_WIDTH-1:0] addr_t;

    // Signal code, upper nibble of a byte
    // Anything outside this list is plain data
    typedef enum logic [3:0] {
        SIG_KEY = 4'd1,
        SIG_CRC = 4'd2,
        SIG_RGC = 4'd3,
        SIG_ACK = 4'd4,
        SIG_BOS = 4'd5,
        SIG_DAT = 4'd6,
        SIG_EOS = 4'd7
    } sig_code_e;

    // Control register 1 bit positions
    typedef enum logic [2:0] {
        CLI_GRNT = 3'd0,
        IRQ_EN   = 3'd1,
        KEY_RDY  = 3'd2,
        STR_BOS  = 3'd3,
        STR_DAT  = 3'd4,
        STR_EOS  = 3'd5,
        STR_BYT  = 3'd6
    } ctl1_bit_e;

    // Control register 2 bit positions
    typedef enum logic [1:0] {
        SYS_REQ  = 2'd0,
        SYS_GRNT = 2'd1,
        DEV_TRX  = 2'd2,
        TRX_CMP  = 2'd3
    } ctl2_bit_e;

    // Controller FSM states
    typedef enum logic [3:0] {
        DEV_IDLE,
        DEV_CHECK,
        KEY_WAIT,
        KEY_ACK,
        KEY_EXIT,
        RGC_START,
        RGC_SEND,
        CLI_IDLE,
        CLI_CHECK,
        SYS_IDLE,
        TRX_START,
        TRX_SEND
    } link_state_e;

endpackage

// ==== uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ------------------------------
// Data path widths
// ------------------------------
`define UART_DATA_WIDTH 8
`define UART_ADDR_WIDTH 3

// Serial bit period in clock cycles
`define UART_CLKS_PER_BIT 8

// ------------------------------
// Register map
// ------------------------------
`define UART_ADDR_KEY   3'd0
`define UART_ADDR_CTL1  3'd1
`define UART_ADDR_CTL2  3'd2
`define UART_ADDR_RXBUF 3'd3
`define UART_ADDR_TXBUF 3'd4

`endif
